// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// data and address word
	typedef logic [31:0] word_t;

	// general register number
	typedef logic [4:0] reg_addr_t;

	// cp0 register number
	typedef logic [4:0] cp0_addr_t;

	// byte lanes, bit 3 is bits 31:24 (offset 0, big-endian)
	typedef logic [3:0] sel_t;

	// memory opcodes, alu-op encoding
	typedef enum logic [7:0] {
		op_none = 8'b0000_0000,
		op_lb   = 8'b1110_0000,
		op_lbu  = 8'b1110_0100,
		op_lh   = 8'b1110_0001,
		op_lhu  = 8'b1110_0101,
		op_lw   = 8'b1110_0011,
		op_sb   = 8'b1110_1000,
		op_sh   = 8'b1110_1001,
		op_sw   = 8'b1110_1011
	} mem_op_e;

	// final exception codes
	typedef enum logic [31:0] {
		exc_none    = 32'h0000_0000,
		exc_int     = 32'h0000_0001,
		exc_adel    = 32'h0000_0004,
		exc_ades    = 32'h0000_0005,
		exc_syscall = 32'h0000_0008,
		exc_ri      = 32'h0000_000a,
		exc_eret    = 32'h0000_000e
	} exc_e;

	// flag positions in the incoming exception word
	localparam int exc_bit_syscall = 8;
	localparam int exc_bit_ri = 10;
	localparam int exc_bit_eret = 12;

	// cp0 register numbers
	localparam cp0_addr_t cp0_status = 5'd12;
	localparam cp0_addr_t cp0_cause = 5'd13;
	localparam cp0_addr_t cp0_epc = 5'd14;

	// lane selects
	localparam sel_t sel_none = 4'b0000;
	localparam sel_t sel_all = 4'b1111;
	localparam sel_t sel_byte_hi = 4'b1000;
	localparam sel_t sel_half_hi = 4'b1100;
	localparam sel_t sel_half_lo = 4'b0011;

endpackage

`default_nettype wire

// ==== cp0_forward.sv ====
`default_nettype none

module cp0_forward (
	input  wire                     rst_i,
	input  wire  mem_pkg::word_t    cp0_status_i,
	input  wire  mem_pkg::word_t    cp0_cause_i,
	input  wire  mem_pkg::word_t    cp0_epc_i,
	input  wire                     wb_cp0_we_i,
	input  wire  mem_pkg::cp0_addr_t wb_cp0_addr_i,
	input  wire  mem_pkg::word_t    wb_cp0_data_i,
	output mem_pkg::word_t          status_o,
	output mem_pkg::word_t          cause_o,
	output mem_pkg::word_t          epc_o
);

	logic hit_status;
	logic hit_cause;
	logic hit_epc;

	// writeback is writing this register right now
	assign hit_status = wb_cp0_we_i && (wb_cp0_addr_i == mem_pkg::cp0_status);
	assign hit_cause = wb_cp0_we_i && (wb_cp0_addr_i == mem_pkg::cp0_cause);
	assign hit_epc = wb_cp0_we_i && (wb_cp0_addr_i == mem_pkg::cp0_epc);

	always_comb begin
		if (rst_i) begin
			status_o = '0;
			cause_o = '0;
			epc_o = '0;
		end else begin
			// newer value from writeback wins over cp0
			status_o = hit_status ? wb_cp0_data_i : cp0_status_i;
			cause_o = hit_cause ? wb_cp0_data_i : cp0_cause_i;
			epc_o = hit_epc ? wb_cp0_data_i : cp0_epc_i;
		end
	end

endmodule

`default_nettype wire

// ==== except_resolve.sv ====
`default_nettype none

module except_resolve (
	input  wire  mem_pkg::word_t excepttype_i,
	input  wire  mem_pkg::word_t inst_addr_i,
	input  wire                  adel_i,
	input  wire                  ades_i,
	input  wire  mem_pkg::word_t status_i,
	input  wire  mem_pkg::word_t cause_i,
	output mem_pkg::exc_e        exc_o
);

	logic int_pending;
	logic int_enabled;

	// pending and unmasked
	assign int_pending = |(cause_i[15:8] & status_i[15:8]);
	// exl clear, ie set
	assign int_enabled = !status_i[1] && status_i[0];

	always_comb begin
		exc_o = mem_pkg::exc_none;
		// a zero pc marks a bubble, nothing to report
		if (inst_addr_i != '0) begin
			if (int_pending && int_enabled) begin
				exc_o = mem_pkg::exc_int;
			end else if (adel_i) begin
				exc_o = mem_pkg::exc_adel;
			end else if (ades_i) begin
				exc_o = mem_pkg::exc_ades;
			end else if (excepttype_i[mem_pkg::exc_bit_syscall]) begin
				exc_o = mem_pkg::exc_syscall;
			end else if (excepttype_i[mem_pkg::exc_bit_ri]) begin
				exc_o = mem_pkg::exc_ri;
			end else if (excepttype_i[mem_pkg::exc_bit_eret]) begin
				exc_o = mem_pkg::exc_eret;
			end
		end
	end

endmodule

`default_nettype wire

// ==== mem_request.sv ====
`default_nettype none

module mem_request (
	input  wire                      clk,
	input  wire                      rst_i,
	input  wire  mem_pkg::mem_op_e   op_i,
	input  wire  mem_pkg::word_t     addr_i,
	input  wire  mem_pkg::word_t     reg2_i,
	input  wire  mem_pkg::exc_e      exc_i,
	output logic                     adel_o,
	output logic                     ades_o,
	output mem_pkg::word_t           mem_addr_o,
	output mem_pkg::sel_t            mem_sel_o,
	output mem_pkg::word_t           mem_data_o,
	output logic                     mem_ce_o,
	output logic                     mem_we_o,
	output mem_pkg::exc_e            excepttype_o,
	output mem_pkg::word_t           bad_v_addr_o,
	output mem_pkg::mem_op_e         op_q_o,
	output logic [1:0]               off_q_o
);

	logic [1:0] off;
	mem_pkg::sel_t byte_sel;
	mem_pkg::sel_t half_sel;
	mem_pkg::sel_t sel_d;
	mem_pkg::word_t data_d;
	logic ce_d;
	logic we_d;

	assign off = addr_i[1:0];

	// big-endian lanes, offset 0 is the top byte
	assign byte_sel = mem_pkg::sel_byte_hi >> off;
	assign half_sel = off[1] ? mem_pkg::sel_half_lo : mem_pkg::sel_half_hi;

	always_comb begin
		sel_d = mem_pkg::sel_none;
		data_d = '0;
		ce_d = 1'b0;
		we_d = 1'b0;
		adel_o = 1'b0;
		ades_o = 1'b0;
		case (op_i)
			mem_pkg::op_lb, mem_pkg::op_lbu: begin
				ce_d = 1'b1;
				sel_d = byte_sel;
			end
			mem_pkg::op_lh, mem_pkg::op_lhu: begin
				if (!off[0]) begin
					ce_d = 1'b1;
					sel_d = half_sel;
				end else begin
					adel_o = 1'b1;
				end
			end
			mem_pkg::op_lw: begin
				if (off == 2'b00) begin
					ce_d = 1'b1;
					sel_d = mem_pkg::sel_all;
				end else begin
					adel_o = 1'b1;
				end
			end
			mem_pkg::op_sb: begin
				ce_d = 1'b1;
				we_d = 1'b1;
				sel_d = byte_sel;
				// memory picks the lane, so replicate
				data_d = {4{reg2_i[7:0]}};
			end
			mem_pkg::op_sh: begin
				if (!off[0]) begin
					ce_d = 1'b1;
					we_d = 1'b1;
					sel_d = half_sel;
					data_d = {2{reg2_i[15:0]}};
				end else begin
					ades_o = 1'b1;
				end
			end
			mem_pkg::op_sw: begin
				if (off == 2'b00) begin
					ce_d = 1'b1;
					we_d = 1'b1;
					sel_d = mem_pkg::sel_all;
					data_d = reg2_i;
				end else begin
					ades_o = 1'b1;
				end
			end
			default: begin
				// bubble, memory stays idle
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			mem_addr_o <= '0;
			mem_sel_o <= mem_pkg::sel_none;
			mem_data_o <= '0;
			mem_ce_o <= 1'b0;
			mem_we_o <= 1'b0;
			excepttype_o <= mem_pkg::exc_none;
			bad_v_addr_o <= '0;
			op_q_o <= mem_pkg::op_none;
			off_q_o <= 2'b00;
		end else begin
			mem_addr_o <= (op_i == mem_pkg::op_none) ? '0 : addr_i;
			mem_sel_o <= sel_d;
			mem_data_o <= data_d;
			mem_ce_o <= ce_d;
			// any exception cancels the store
			mem_we_o <= we_d && (exc_i == mem_pkg::exc_none);
			excepttype_o <= exc_i;
			bad_v_addr_o <= (adel_o || ades_o) ? addr_i : '0;
			op_q_o <= op_i;
			off_q_o <= off;
		end
	end

endmodule

`default_nettype wire

// ==== load_align.sv ====
`default_nettype none

module load_align (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire  mem_pkg::mem_op_e    op_i,
	input  wire  [1:0]                off_i,
	input  wire  mem_pkg::word_t      mem_data_i,
	input  wire  mem_pkg::exc_e       exc_i,
	input  wire  mem_pkg::reg_addr_t  wd_i,
	input  wire                       wreg_i,
	input  wire  mem_pkg::word_t      wdata_i,
	output mem_pkg::reg_addr_t        wd_o,
	output logic                      wreg_o,
	output mem_pkg::word_t            wdata_o
);

	logic [7:0] ld_byte;
	logic [15:0] ld_half;
	logic is_load;
	mem_pkg::word_t result;

	// offset 0 sits in bits 31:24
	always_comb begin
		case (off_i)
			2'b00: ld_byte = mem_data_i[31:24];
			2'b01: ld_byte = mem_data_i[23:16];
			2'b10: ld_byte = mem_data_i[15:8];
			default: ld_byte = mem_data_i[7:0];
		endcase
	end

	assign ld_half = off_i[1] ? mem_data_i[15:0] : mem_data_i[31:16];

	always_comb begin
		is_load = 1'b1;
		case (op_i)
			mem_pkg::op_lb: result = {{24{ld_byte[7]}}, ld_byte};
			mem_pkg::op_lbu: result = {24'h0, ld_byte};
			mem_pkg::op_lh: result = {{16{ld_half[15]}}, ld_half};
			mem_pkg::op_lhu: result = {16'h0, ld_half};
			mem_pkg::op_lw: result = mem_data_i;
			default: begin
				is_load = 1'b0;
				result = wdata_i;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wd_o <= '0;
			wreg_o <= 1'b0;
			wdata_o <= '0;
		end else begin
			wd_o <= wd_i;
			wreg_o <= wreg_i;
			// faulting load never reached memory
			wdata_o <= (is_load && exc_i != mem_pkg::exc_none) ? '0 : result;
		end
	end

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`default_nettype none

module mem_stage (
	input  wire                        clk,
	input  wire                        rst_i,
	input  wire  mem_pkg::mem_op_e     op_i,
	input  wire  mem_pkg::word_t       addr_i,
	input  wire  mem_pkg::word_t       reg2_i,
	input  wire  mem_pkg::reg_addr_t   wd_i,
	input  wire                        wreg_i,
	input  wire  mem_pkg::word_t       wdata_i,
	input  wire  mem_pkg::word_t       excepttype_i,
	input  wire                        in_delayslot_i,
	input  wire  mem_pkg::word_t       inst_addr_i,
	input  wire  mem_pkg::word_t       cp0_status_i,
	input  wire  mem_pkg::word_t       cp0_cause_i,
	input  wire  mem_pkg::word_t       cp0_epc_i,
	input  wire                        wb_cp0_we_i,
	input  wire  mem_pkg::cp0_addr_t   wb_cp0_addr_i,
	input  wire  mem_pkg::word_t       wb_cp0_data_i,
	input  wire  mem_pkg::word_t       mem_data_i,
	output mem_pkg::word_t             mem_addr_o,
	output mem_pkg::sel_t              mem_sel_o,
	output mem_pkg::word_t             mem_data_o,
	output logic                       mem_ce_o,
	output logic                       mem_we_o,
	output mem_pkg::exc_e              excepttype_o,
	output mem_pkg::word_t             bad_v_addr_o,
	output mem_pkg::word_t             epc_o,
	output logic                       in_delayslot_o,
	output mem_pkg::word_t             inst_addr_o,
	output mem_pkg::reg_addr_t         wd_o,
	output logic                       wreg_o,
	output mem_pkg::word_t             wdata_o
);

	mem_pkg::word_t status_fwd;
	mem_pkg::word_t cause_fwd;
	mem_pkg::word_t epc_fwd;
	mem_pkg::exc_e exc_d;
	logic adel;
	logic ades;
	mem_pkg::mem_op_e op_q;
	logic [1:0] off_q;
	mem_pkg::reg_addr_t wd_q;
	logic wreg_q;
	mem_pkg::word_t wdata_q;

	cp0_forward u_cp0_forward (
		.rst_i         (rst_i),
		.cp0_status_i  (cp0_status_i),
		.cp0_cause_i   (cp0_cause_i),
		.cp0_epc_i     (cp0_epc_i),
		.wb_cp0_we_i   (wb_cp0_we_i),
		.wb_cp0_addr_i (wb_cp0_addr_i),
		.wb_cp0_data_i (wb_cp0_data_i),
		.status_o      (status_fwd),
		.cause_o       (cause_fwd),
		.epc_o         (epc_fwd)
	);

	except_resolve u_except_resolve (
		.excepttype_i (excepttype_i),
		.inst_addr_i  (inst_addr_i),
		.adel_i       (adel),
		.ades_i       (ades),
		.status_i     (status_fwd),
		.cause_i      (cause_fwd),
		.exc_o        (exc_d)
	);

	mem_request u_mem_request (
		.clk          (clk),
		.rst_i        (rst_i),
		.op_i         (op_i),
		.addr_i       (addr_i),
		.reg2_i       (reg2_i),
		.exc_i        (exc_d),
		.adel_o       (adel),
		.ades_o       (ades),
		.mem_addr_o   (mem_addr_o),
		.mem_sel_o    (mem_sel_o),
		.mem_data_o   (mem_data_o),
		.mem_ce_o     (mem_ce_o),
		.mem_we_o     (mem_we_o),
		.excepttype_o (excepttype_o),
		.bad_v_addr_o (bad_v_addr_o),
		.op_q_o       (op_q),
		.off_q_o      (off_q)
	);

	// stage one copies of the pass-through fields
	always_ff @(posedge clk) begin
		if (rst_i) begin
			wd_q <= '0;
			wreg_q <= 1'b0;
			wdata_q <= '0;
			epc_o <= '0;
			in_delayslot_o <= 1'b0;
			inst_addr_o <= '0;
		end else begin
			wd_q <= wd_i;
			wreg_q <= wreg_i;
			wdata_q <= wdata_i;
			epc_o <= epc_fwd;
			in_delayslot_o <= in_delayslot_i;
			inst_addr_o <= inst_addr_i;
		end
	end

	// read word comes back during the request cycle
	load_align u_load_align (
		.clk        (clk),
		.rst_i      (rst_i),
		.op_i       (op_q),
		.off_i      (off_q),
		.mem_data_i (mem_data_i),
		.exc_i      (excepttype_o),
		.wd_i       (wd_q),
		.wreg_i     (wreg_q),
		.wdata_i    (wdata_q),
		.wd_o       (wd_o),
		.wreg_o     (wreg_o),
		.wdata_o    (wdata_o)
	);

endmodule

`default_nettype wire

// ==== mem_stage_checker.sv ====
`default_nettype none

module mem_stage_checker (
	input wire        clk,
	input wire        rst_i,
	input wire        mem_ce_o,
	input wire        mem_we_o,
	input wire        wreg_o,
	input wire [31:0] excepttype_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// a write is always a memory access
	we_needs_ce: assert property (@(posedge clk) disable iff (rst_i) mem_we_o |-> mem_ce_o)
		else $error("write enable seen without chip enable");

	// any exception cancels the store
	exc_blocks_we: assert property (@(posedge clk) disable iff (rst_i)
		(excepttype_o != '0) |-> !mem_we_o)
		else $error("store left enabled while an exception is reported");

	// outputs are quiet one cycle after reset
	idle_after_rst: assert property (@(posedge clk) rst_i |=> (!mem_ce_o && !mem_we_o && !wreg_o))
		else $error("memory or writeback active right after reset");

endmodule

bind mem_stage mem_stage_checker u_checker (
	.clk          (clk),
	.rst_i        (rst_i),
	.mem_ce_o     (mem_ce_o),
	.mem_we_o     (mem_we_o),
	.wreg_o       (wreg_o),
	.excepttype_o (excepttype_o)
);

`default_nettype wire

// ==== mem_stage_tb.sv ====
`default_nettype none

module mem_stage_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// upper bound on the test length in cycles
	localparam int test_cycles = 200;
	localparam int timeout_cycles = 10 * test_cycles;
	localparam mem_pkg::word_t alu_result = 32'h5a5a_c3c3;
	localparam mem_pkg::word_t item_pc = 32'hbfc0_0400;
	localparam mem_pkg::reg_addr_t dest_reg = 5'd3;

	logic clk = 1'b0;
	logic rst_i;
	mem_pkg::mem_op_e op_i;
	mem_pkg::word_t addr_i, reg2_i, wdata_i, excepttype_i, inst_addr_i;
	mem_pkg::reg_addr_t wd_i;
	logic wreg_i, in_delayslot_i, wb_cp0_we_i;
	mem_pkg::word_t cp0_status_i, cp0_cause_i, cp0_epc_i, wb_cp0_data_i, mem_data_i;
	mem_pkg::cp0_addr_t wb_cp0_addr_i;
	mem_pkg::word_t mem_addr_o, mem_data_o, bad_v_addr_o, epc_o, inst_addr_o, wdata_o;
	mem_pkg::sel_t mem_sel_o;
	logic mem_ce_o, mem_we_o, in_delayslot_o, wreg_o;
	mem_pkg::exc_e excepttype_o;
	mem_pkg::reg_addr_t wd_o;

	// cp0 and writeback values picked up by the next item
	mem_pkg::word_t status_v, cause_v, epc_v, wb_data_v;
	mem_pkg::cp0_addr_t wb_addr_v;
	logic wb_we_v;
	// delay slot flag of the next item
	logic slot_v;

	mem_pkg::word_t mem [0:15];
	mem_pkg::word_t init_mem [0:15];
	integer seed;
	int cycle_count = 0;

	mem_stage uut (.*);

	always #2 clk = ~clk;

	// read word is on the bus while the request is
	assign mem_data_i = mem[mem_addr_o[5:2]];

	always @(posedge clk) begin
		if (rst_i) begin
			for (int k = 0; k < 16; k++) begin
				mem[k] <= init_mem[k];
			end
		end else if (mem_ce_o && mem_we_o) begin
			if (mem_sel_o[3]) mem[mem_addr_o[5:2]][31:24] <= mem_data_o[31:24];
			if (mem_sel_o[2]) mem[mem_addr_o[5:2]][23:16] <= mem_data_o[23:16];
			if (mem_sel_o[1]) mem[mem_addr_o[5:2]][15:8] <= mem_data_o[15:8];
			if (mem_sel_o[0]) mem[mem_addr_o[5:2]][7:0] <= mem_data_o[7:0];
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("tests failed");
			$fatal(1, "timeout, tests did not finish within %0d cycles", timeout_cycles);
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("** Error: %s expected %h, got %h", name, exp, act);
			$display("tests failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	// offset 0 maps to lane bit 3
	function automatic logic [3:0] lane_sel(input mem_pkg::mem_op_e op, input logic [1:0] off);
		case (op)
			mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sb: return 4'b0001 << (2'd3 - off);
			mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh: return 4'b1100 >> off;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic mem_pkg::word_t load_value(input mem_pkg::mem_op_e op,
			input mem_pkg::word_t word, input logic [1:0] off);
		int pos;
		logic [7:0] b;
		logic [15:0] h;
		pos = 24 - 8 * int'(off);
		b = 8'(word >> pos);
		h = 16'(word >> (pos - 8 * int'(off[0] == 1'b0)));
		case (op)
			mem_pkg::op_lb: return {{24{b[7]}}, b};
			mem_pkg::op_lbu: return {24'h0, b};
			mem_pkg::op_lh: return {{16{h[15]}}, h};
			mem_pkg::op_lhu: return {16'h0, h};
			default: return word;
		endcase
	endfunction

	task automatic drive_item(input mem_pkg::mem_op_e op, input mem_pkg::word_t addr,
			input mem_pkg::word_t reg2, input mem_pkg::word_t flags, input mem_pkg::word_t pc);
		@(posedge clk);
		op_i <= op;
		addr_i <= addr;
		reg2_i <= reg2;
		wd_i <= dest_reg;
		wreg_i <= 1'b1;
		wdata_i <= alu_result;
		excepttype_i <= flags;
		in_delayslot_i <= slot_v;
		inst_addr_i <= pc;
		cp0_status_i <= status_v;
		cp0_cause_i <= cause_v;
		cp0_epc_i <= epc_v;
		wb_cp0_we_i <= wb_we_v;
		wb_cp0_addr_i <= wb_addr_v;
		wb_cp0_data_i <= wb_data_v;
	endtask

	task automatic drive_idle();
		@(posedge clk);
		op_i <= mem_pkg::op_none;
		addr_i <= '0;
		reg2_i <= '0;
		wreg_i <= 1'b0;
		wdata_i <= '0;
		excepttype_i <= '0;
		in_delayslot_i <= 1'b0;
		inst_addr_i <= '0;
		wb_cp0_we_i <= 1'b0;
	endtask

	// leaves the stage-one outputs of the item on view
	task automatic issue_one(input mem_pkg::mem_op_e op, input mem_pkg::word_t addr,
			input mem_pkg::word_t reg2, input mem_pkg::word_t flags, input mem_pkg::word_t pc);
		drive_item(op, addr, reg2, flags, pc);
		drive_idle();
		@(negedge clk);
		check_val("inst_addr_o", pc, inst_addr_o);
		check_val("in_delayslot_o", 32'(slot_v), 32'(in_delayslot_o));
	endtask

	task automatic check_quiet();
		check_val("mem_ce_o", 32'h0, 32'(mem_ce_o));
		check_val("mem_we_o", 32'h0, 32'(mem_we_o));
		check_val("wreg_o", 32'h0, 32'(wreg_o));
		check_val("excepttype_o", 32'h0, excepttype_o);
	endtask

	task automatic test_reset();
		for (int c = 0; c < 10; c++) begin
			@(posedge clk);
			if (c == 9) rst_i <= 1'b0;
			@(negedge clk);
			check_quiet();
		end
		@(negedge clk);
		check_quiet();
	endtask

	task automatic test_loads();
		mem_pkg::mem_op_e ops [13];
		mem_pkg::word_t addrs [13];
		mem_pkg::word_t exp_data [13];
		for (int i = 0; i < 4; i++) begin
			ops[i] = mem_pkg::op_lb;
			addrs[i] = 32'h100 + i;
			ops[i + 4] = mem_pkg::op_lbu;
			addrs[i + 4] = 32'h104 + i;
		end
		ops[8] = mem_pkg::op_lh;
		addrs[8] = 32'h108;
		ops[9] = mem_pkg::op_lh;
		addrs[9] = 32'h10a;
		ops[10] = mem_pkg::op_lhu;
		addrs[10] = 32'h10c;
		ops[11] = mem_pkg::op_lhu;
		addrs[11] = 32'h10e;
		ops[12] = mem_pkg::op_lw;
		addrs[12] = 32'h110;
		for (int i = 0; i < 13; i++) begin
			exp_data[i] = load_value(ops[i], mem[addrs[i][5:2]], addrs[i][1:0]);
		end
		// select one cycle and data two cycles after issue
		for (int i = 0; i < 15; i++) begin
			if (i < 13) begin
				drive_item(ops[i], addrs[i], 32'h0, 32'h0, item_pc);
			end else begin
				drive_idle();
			end
			@(negedge clk);
			if (i >= 1 && i <= 13) begin
				check_val("mem_sel_o", 32'(lane_sel(ops[i - 1], addrs[i - 1][1:0])),
					32'(mem_sel_o));
				check_val("mem_ce_o", 32'h1, 32'(mem_ce_o));
			end
			if (i >= 2) check_val("wdata_o", exp_data[i - 2], wdata_o);
		end
	endtask

	task automatic check_store(input mem_pkg::mem_op_e op, input mem_pkg::word_t addr,
			input mem_pkg::word_t reg2, input mem_pkg::word_t exp_data);
		issue_one(op, addr, reg2, 32'h0, item_pc);
		check_val("mem_addr_o", {addr[31:2], 2'b00}, {mem_addr_o[31:2], 2'b00});
		check_val("mem_sel_o", 32'(lane_sel(op, addr[1:0])), 32'(mem_sel_o));
		check_val("mem_data_o", exp_data, mem_data_o);
		check_val("mem_we_o", 32'h1, 32'(mem_we_o));
		check_val("mem_ce_o", 32'h1, 32'(mem_ce_o));
	endtask

	task automatic check_load(input mem_pkg::word_t addr, input mem_pkg::word_t exp_data);
		issue_one(mem_pkg::op_lw, addr, 32'h0, 32'h0, item_pc);
		@(negedge clk);
		check_val("wdata_o", exp_data, wdata_o);
		check_val("wd_o", 32'(dest_reg), 32'(wd_o));
		check_val("wreg_o", 32'h1, 32'(wreg_o));
	endtask

	task automatic test_stores();
		mem_pkg::word_t old_word;
		old_word = mem[1];
		check_store(mem_pkg::op_sb, 32'h105, 32'h7777_77a5, 32'ha5a5_a5a5);
		check_store(mem_pkg::op_sh, 32'h106, 32'h8888_1234, 32'h1234_1234);
		check_store(mem_pkg::op_sw, 32'h108, 32'hcafe_f00d, 32'hcafe_f00d);
		check_load(32'h104, {old_word[31:24], 8'ha5, 16'h1234});
		check_load(32'h108, 32'hcafe_f00d);
	endtask

	task automatic check_misaligned(input mem_pkg::mem_op_e op, input mem_pkg::word_t addr,
			input mem_pkg::exc_e exc, input logic is_load);
		issue_one(op, addr, 32'h1234_5678, 32'h0, item_pc);
		check_val("excepttype_o", exc, excepttype_o);
		check_val("bad_v_addr_o", addr, bad_v_addr_o);
		check_val("mem_ce_o", 32'h0, 32'(mem_ce_o));
		check_val("mem_we_o", 32'h0, 32'(mem_we_o));
		@(negedge clk);
		if (is_load) check_val("wdata_o", 32'h0, wdata_o);
	endtask

	task automatic test_misaligned();
		// faulting items sit in a delay slot here
		slot_v = 1'b1;
		check_misaligned(mem_pkg::op_lh, 32'h101, mem_pkg::exc_adel, 1'b1);
		check_misaligned(mem_pkg::op_lw, 32'h102, mem_pkg::exc_adel, 1'b1);
		check_misaligned(mem_pkg::op_sh, 32'h103, mem_pkg::exc_ades, 1'b0);
		check_misaligned(mem_pkg::op_sw, 32'h101, mem_pkg::exc_ades, 1'b0);
		slot_v = 1'b0;
	endtask

	task automatic test_priority();
		// pending and unmasked interrupt line 2 with ie set
		status_v = 32'h0000_0401;
		cause_v = 32'h0000_0400;
		issue_one(mem_pkg::op_lh, 32'h101, 32'h0, 32'h0, item_pc);
		check_val("excepttype_o", mem_pkg::exc_int, excepttype_o);
		status_v = 32'h0;
		cause_v = 32'h0;
		issue_one(mem_pkg::op_sw, 32'h108, 32'hffff_ffff, 32'h0000_0100, item_pc);
		check_val("excepttype_o", mem_pkg::exc_syscall, excepttype_o);
		check_val("mem_we_o", 32'h0, 32'(mem_we_o));
		issue_one(mem_pkg::op_none, 32'h0, 32'h0, 32'h0000_0400, item_pc);
		check_val("excepttype_o", mem_pkg::exc_ri, excepttype_o);
		issue_one(mem_pkg::op_none, 32'h0, 32'h0, 32'h0000_1000, item_pc);
		check_val("excepttype_o", mem_pkg::exc_eret, excepttype_o);
		issue_one(mem_pkg::op_none, 32'h0, 32'h0, 32'h0000_0100, 32'h0);
		check_val("excepttype_o", mem_pkg::exc_none, excepttype_o);
	endtask

	task automatic test_cp0_forward();
		status_v = 32'h0000_0400;
		cause_v = 32'h0000_0400;
		wb_we_v = 1'b1;
		wb_addr_v = mem_pkg::cp0_status;
		wb_data_v = 32'h0000_0401;
		issue_one(mem_pkg::op_none, 32'h0, 32'h0, 32'h0, item_pc);
		check_val("excepttype_o", mem_pkg::exc_int, excepttype_o);
		status_v = 32'h0;
		cause_v = 32'h0;
		epc_v = 32'h1111_1111;
		wb_addr_v = mem_pkg::cp0_epc;
		wb_data_v = 32'h8000_0180;
		issue_one(mem_pkg::op_none, 32'h0, 32'h0, 32'h0, item_pc);
		check_val("epc_o", 32'h8000_0180, epc_o);
		check_val("excepttype_o", mem_pkg::exc_none, excepttype_o);
		wb_we_v = 1'b0;
		// alu result passes through a non-load
		@(negedge clk);
		check_val("wdata_o", alu_result, wdata_o);
	endtask

	initial begin
		seed = 65;
		for (int k = 0; k < 16; k++) begin
			init_mem[k] = $random(seed);
		end
		status_v = '0;
		cause_v = '0;
		epc_v = '0;
		wb_we_v = 1'b0;
		wb_addr_v = '0;
		wb_data_v = '0;
		slot_v = 1'b0;
		rst_i <= 1'b1;
		op_i <= mem_pkg::op_none;
		addr_i <= '0;
		reg2_i <= '0;
		wd_i <= '0;
		wreg_i <= 1'b0;
		wdata_i <= '0;
		excepttype_i <= '0;
		in_delayslot_i <= 1'b0;
		inst_addr_i <= '0;
		cp0_status_i <= '0;
		cp0_cause_i <= '0;
		cp0_epc_i <= '0;
		wb_cp0_we_i <= 1'b0;
		wb_cp0_addr_i <= '0;
		wb_cp0_data_i <= '0;
		test_reset();
		test_loads();
		test_stores();
		test_misaligned();
		test_priority();
		test_cp0_forward();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
mem_pkg.sv
cp0_forward.sv
except_resolve.sv
mem_request.sv
load_align.sv
mem_stage.sv
mem_stage_checker.sv
mem_stage_tb.sv

// ==== run.sh ====
#!/bin/bash
# build with verilator, then look for the pass line in the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module mem_stage_tb -o mem_stage_sim &&
./obj_dir/mem_stage_sim | grep -x "all tests passed" &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }
